// ==== prf_cfg.svh ====
// prf config: sizes shared by the physical register file subsystem
`ifndef PRF_CFG_SVH
`define PRF_CFG_SVH

// ---------------------------------------------------------------------------
// channel widths
// ---------------------------------------------------------------------------

// dispatch, issue and broadcast lanes per cycle
`define PRF_DP_NUM 2

// ---------------------------------------------------------------------------
// register file geometry
// ---------------------------------------------------------------------------

`define PRF_PHY_REG_NUM 64  // physical registers
`define PRF_XLEN 32         // data word width
`define PRF_TAG_W 6         // log2 of PRF_PHY_REG_NUM

// hardwired zero, reads as 0 and ignores writes
`define PRF_ZERO_REG 0

`endif

// ==== prf_pkg.sv ====
// prf package: tag and data word types shared across the subsystem
`include "prf_cfg.svh"

package prf_pkg;

  // -------------------------------------------------------------------------
  // tags
  // -------------------------------------------------------------------------

  // physical register tag, comes ready-made from rename
  typedef logic [`PRF_TAG_W-1:0] preg_t;

  // -------------------------------------------------------------------------
  // data
  // -------------------------------------------------------------------------

  typedef logic [`PRF_XLEN-1:0] xlen_t;  // one register value

endpackage

// ==== prf.sv ====
// prf: multi-ported physical register file with zero reg and broadcast bypass
`include "prf_cfg.svh"

module prf (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // write ports, one per broadcast lane
  input  logic           [`PRF_DP_NUM-1:0]    wr_en_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    wr_addr_i,
  input  prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    wr_data_i,
  // read ports, two per issue lane
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    rd_addr1_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    rd_addr2_i,
  output prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    rd_data1_o,
  output prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    rd_data2_o
);

  prf_pkg::xlen_t regs_q [`PRF_PHY_REG_NUM];  // storage array

  // ---------------------------------------------------------------------------
  // read path
  // ---------------------------------------------------------------------------

  // one read port. stored word, overridden by a matching broadcast
  // lane, later lane wins. zero tag forced to 0 last
  function automatic prf_pkg::xlen_t read_port(input prf_pkg::preg_t addr);
    prf_pkg::xlen_t data;
    data = regs_q[addr];
    for (int w = 0; w < `PRF_DP_NUM; w++) begin
      if (wr_en_i[w] && (wr_addr_i[w] == addr)) begin
        data = wr_data_i[w];  // same-cycle bypass
      end
    end
    if (addr == prf_pkg::preg_t'(`PRF_ZERO_REG)) begin
      data = '0;  // hardwired zero
    end
    return data;
  endfunction

  always_comb begin
    for (int c = 0; c < `PRF_DP_NUM; c++) begin
      rd_data1_o[c] = read_port(rd_addr1_i[c]);  // src1 of lane c
      rd_data2_o[c] = read_port(rd_addr2_i[c]);  // src2 of lane c
    end
  end

  // ---------------------------------------------------------------------------
  // write path
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 0; r < `PRF_PHY_REG_NUM; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int w = 0; w < `PRF_DP_NUM; w++) begin
        // zero reg may get written, read path masks it anyway
        if (wr_en_i[w]) begin
          regs_q[wr_addr_i[w]] <= wr_data_i[w];
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------

  // completion side must never retire two results into one tag at once
  for (genvar a = 0; a < `PRF_DP_NUM; a++) begin : g_wr_a
    for (genvar b = a + 1; b < `PRF_DP_NUM; b++) begin : g_wr_b
      a_no_dup_write : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(wr_en_i[a] && wr_en_i[b] && (wr_addr_i[a] == wr_addr_i[b]))
      ) else $error("prf: lanes %0d and %0d write tag %0d together",
                    a, b, wr_addr_i[a]);
    end
  end

endmodule

// ==== prf_busy_table.sv ====
// prf busy table: one ready bit per physical reg with same-cycle wakeup
`include "prf_cfg.svh"

module prf_busy_table (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // dispatch side, marks dest pending
  input  logic           [`PRF_DP_NUM-1:0]    alloc_valid_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    alloc_tag_i,
  // broadcast side, marks dest ready
  input  logic           [`PRF_DP_NUM-1:0]    bc_valid_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    bc_tag_i,
  // issue side lookups
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    chk_tag1_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    chk_tag2_i,
  output logic           [`PRF_DP_NUM-1:0]    chk_rdy1_o,
  output logic           [`PRF_DP_NUM-1:0]    chk_rdy2_o
);

  logic [`PRF_PHY_REG_NUM-1:0] rdy_q;  // 1 = value present

  // ---------------------------------------------------------------------------
  // lookup
  // ---------------------------------------------------------------------------

  // ready if stored, being broadcast now, or the zero reg
  function automatic logic is_ready(input prf_pkg::preg_t tag);
    logic rdy;
    rdy = rdy_q[tag];
    for (int b = 0; b < `PRF_DP_NUM; b++) begin
      rdy = rdy | (bc_valid_i[b] && (bc_tag_i[b] == tag));  // wakeup bypass
    end
    rdy = rdy | (tag == prf_pkg::preg_t'(`PRF_ZERO_REG));
    return rdy;
  endfunction

  always_comb begin
    for (int c = 0; c < `PRF_DP_NUM; c++) begin
      chk_rdy1_o[c] = is_ready(chk_tag1_i[c]);
      chk_rdy2_o[c] = is_ready(chk_tag2_i[c]);
    end
  end

  // ---------------------------------------------------------------------------
  // update
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdy_q <= '1;  // nothing in flight out of reset
    end else begin
      for (int c = 0; c < `PRF_DP_NUM; c++) begin
        if (alloc_valid_i[c]) rdy_q[alloc_tag_i[c]] <= 1'b0;  // now pending
      end
      for (int c = 0; c < `PRF_DP_NUM; c++) begin
        if (bc_valid_i[c]) rdy_q[bc_tag_i[c]] <= 1'b1;  // result arrived
      end
    end
  end

  // a tag cannot be handed out by rename while its old value still completes
  for (genvar a = 0; a < `PRF_DP_NUM; a++) begin : g_chk_a
    for (genvar b = 0; b < `PRF_DP_NUM; b++) begin : g_chk_b
      a_alloc_vs_bc : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(alloc_valid_i[a] && bc_valid_i[b] && (alloc_tag_i[a] == bc_tag_i[b]))
      ) else $error("busy table: alloc %0d and bc %0d hit tag %0d",
                    a, b, alloc_tag_i[a]);
    end
  end

endmodule

// ==== operand_read.sv ====
// operand read: issue-side stage that fetches and registers source operands
`include "prf_cfg.svh"

module operand_read (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // issue group
  input  logic           [`PRF_DP_NUM-1:0]    iss_valid_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    iss_src1_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    iss_src2_i,
  // register file lookup
  output prf_pkg::preg_t [`PRF_DP_NUM-1:0]    rd_addr1_o,
  output prf_pkg::preg_t [`PRF_DP_NUM-1:0]    rd_addr2_o,
  input  prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    rd_data1_i,
  input  prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    rd_data2_i,
  // busy table lookup
  output prf_pkg::preg_t [`PRF_DP_NUM-1:0]    chk_tag1_o,
  output prf_pkg::preg_t [`PRF_DP_NUM-1:0]    chk_tag2_o,
  input  logic           [`PRF_DP_NUM-1:0]    chk_rdy1_i,
  input  logic           [`PRF_DP_NUM-1:0]    chk_rdy2_i,
  // operands out one cycle after issue
  output logic           [`PRF_DP_NUM-1:0]    opnd_valid_o,
  output prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    opnd1_o,
  output prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    opnd2_o,
  output logic           [`PRF_DP_NUM-1:0]    opnd1_rdy_o,
  output logic           [`PRF_DP_NUM-1:0]    opnd2_rdy_o
);

  // ---------------------------------------------------------------------------
  // lookup routing
  // ---------------------------------------------------------------------------

  // same source tags index both the data array and the ready bits
  assign rd_addr1_o = iss_src1_i;
  assign rd_addr2_o = iss_src2_i;
  assign chk_tag1_o = iss_src1_i;
  assign chk_tag2_o = iss_src2_i;

  // ---------------------------------------------------------------------------
  // output register
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      opnd_valid_o <= '0;
      opnd1_o      <= '0;
      opnd2_o      <= '0;
      opnd1_rdy_o  <= '0;
      opnd2_rdy_o  <= '0;
    end else begin
      for (int c = 0; c < `PRF_DP_NUM; c++) begin
        opnd_valid_o[c] <= iss_valid_i[c];
        if (iss_valid_i[c]) begin
          opnd1_o[c]     <= rd_data1_i[c];  // already bypassed in prf
          opnd2_o[c]     <= rd_data2_i[c];
          opnd1_rdy_o[c] <= chk_rdy1_i[c];
          opnd2_rdy_o[c] <= chk_rdy2_i[c];
        end else begin
          // idle lane shows all zeros
          opnd1_o[c]     <= '0;
          opnd2_o[c]     <= '0;
          opnd1_rdy_o[c] <= 1'b0;
          opnd2_rdy_o[c] <= 1'b0;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------

  // zero tag must come back as a ready zero from both lookups
  for (genvar c = 0; c < `PRF_DP_NUM; c++) begin : g_zero
    a_zero_src : assert property (
      @(posedge clk_i) disable iff (rst_i)
      iss_valid_i[c] |->
        ((iss_src1_i[c] != prf_pkg::preg_t'(`PRF_ZERO_REG)) ||
         ((rd_data1_i[c] == '0) && chk_rdy1_i[c])) &&
        ((iss_src2_i[c] != prf_pkg::preg_t'(`PRF_ZERO_REG)) ||
         ((rd_data2_i[c] == '0) && chk_rdy2_i[c]))
    ) else $error("operand read: lane %0d got a nonzero or busy zero reg", c);
  end

endmodule

// ==== prf_subsys.sv ====
// prf subsystem: register file, busy table and operand read stage
`include "prf_cfg.svh"

module prf_subsys (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // dispatch
  input  logic           [`PRF_DP_NUM-1:0]    alloc_valid_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    alloc_tag_i,
  // broadcast, single-cycle pulse
  input  logic           [`PRF_DP_NUM-1:0]    bc_valid_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    bc_tag_i,
  input  prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    bc_data_i,
  // issue
  input  logic           [`PRF_DP_NUM-1:0]    iss_valid_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    iss_src1_i,
  input  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    iss_src2_i,
  // operands
  output logic           [`PRF_DP_NUM-1:0]    opnd_valid_o,
  output prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    opnd1_o,
  output prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    opnd2_o,
  output logic           [`PRF_DP_NUM-1:0]    opnd1_rdy_o,
  output logic           [`PRF_DP_NUM-1:0]    opnd2_rdy_o
);

  // ---------------------------------------------------------------------------
  // internal lookup nets
  // ---------------------------------------------------------------------------

  prf_pkg::preg_t [`PRF_DP_NUM-1:0] rd_addr1, rd_addr2;  // to prf
  prf_pkg::xlen_t [`PRF_DP_NUM-1:0] rd_data1, rd_data2;  // from prf
  prf_pkg::preg_t [`PRF_DP_NUM-1:0] chk_tag1, chk_tag2;  // to busy table
  logic           [`PRF_DP_NUM-1:0] chk_rdy1, chk_rdy2;  // from busy table

  // broadcast lands here as the write ports
  prf prf_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_en_i    (bc_valid_i),
    .wr_addr_i  (bc_tag_i),
    .wr_data_i  (bc_data_i),
    .rd_addr1_i (rd_addr1),
    .rd_addr2_i (rd_addr2),
    .rd_data1_o (rd_data1),
    .rd_data2_o (rd_data2)
  );

  // same broadcast also wakes the tag
  prf_busy_table prf_busy_table_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .alloc_valid_i (alloc_valid_i),
    .alloc_tag_i   (alloc_tag_i),
    .bc_valid_i    (bc_valid_i),
    .bc_tag_i      (bc_tag_i),
    .chk_tag1_i    (chk_tag1),
    .chk_tag2_i    (chk_tag2),
    .chk_rdy1_o    (chk_rdy1),
    .chk_rdy2_o    (chk_rdy2)
  );

  operand_read operand_read_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .iss_valid_i  (iss_valid_i),
    .iss_src1_i   (iss_src1_i),
    .iss_src2_i   (iss_src2_i),
    .rd_addr1_o   (rd_addr1),
    .rd_addr2_o   (rd_addr2),
    .rd_data1_i   (rd_data1),
    .rd_data2_i   (rd_data2),
    .chk_tag1_o   (chk_tag1),
    .chk_tag2_o   (chk_tag2),
    .chk_rdy1_i   (chk_rdy1),
    .chk_rdy2_i   (chk_rdy2),
    .opnd_valid_o (opnd_valid_o),
    .opnd1_o      (opnd1_o),
    .opnd2_o      (opnd2_o),
    .opnd1_rdy_o  (opnd1_rdy_o),
    .opnd2_rdy_o  (opnd2_rdy_o)
  );

endmodule

// ==== tb_prf_subsys.sv ====
// prf subsystem testbench: replays the pattern file and checks the operand outputs
`include "prf_cfg.svh"

module tb_prf_subsys;

  // ---------------------------------------------------------------------------
  // pattern layout, one line of hex words per cycle
  // ---------------------------------------------------------------------------

  localparam int FIELDS    = 21;  // words per line
  localparam int MAX_LINES = 64;

  localparam int F_TEST  = 0;   // test number, 0 ends the list
  localparam int F_AV    = 1;   // alloc valid vector
  localparam int F_ATAG  = 2;   // alloc tag, lane 0 then lane 1
  localparam int F_BV    = 4;   // broadcast valid vector
  localparam int F_BTAG  = 5;
  localparam int F_BDATA = 7;
  localparam int F_IV    = 9;   // issue valid vector
  localparam int F_SRC   = 10;  // src1/src2 of lane 0, then lane 1
  localparam int F_EV    = 14;  // expected opnd_valid_o
  localparam int F_EDATA = 15;  // expected opnd1/opnd2 of lane 0, then lane 1
  localparam int F_ER1   = 19;  // expected opnd1_rdy_o
  localparam int F_ER2   = 20;  // expected opnd2_rdy_o

  logic                                clk_i;
  logic                                rst_i;
  logic           [`PRF_DP_NUM-1:0]    alloc_valid_i;
  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    alloc_tag_i;
  logic           [`PRF_DP_NUM-1:0]    bc_valid_i;
  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    bc_tag_i;
  prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    bc_data_i;
  logic           [`PRF_DP_NUM-1:0]    iss_valid_i;
  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    iss_src1_i;
  prf_pkg::preg_t [`PRF_DP_NUM-1:0]    iss_src2_i;
  logic           [`PRF_DP_NUM-1:0]    opnd_valid_o;
  prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    opnd1_o;
  prf_pkg::xlen_t [`PRF_DP_NUM-1:0]    opnd2_o;
  logic           [`PRF_DP_NUM-1:0]    opnd1_rdy_o;
  logic           [`PRF_DP_NUM-1:0]    opnd2_rdy_o;

  logic [31:0] pat [MAX_LINES*FIELDS];  // raw pattern words
  int n_pat        = 0;
  int cycles       = 0;
  int cycle_limit  = 0;   // 0 until patterns are loaded
  int err_total    = 0;
  int err_test     = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  prf_subsys prf_subsys_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .alloc_valid_i (alloc_valid_i),
    .alloc_tag_i   (alloc_tag_i),
    .bc_valid_i    (bc_valid_i),
    .bc_tag_i      (bc_tag_i),
    .bc_data_i     (bc_data_i),
    .iss_valid_i   (iss_valid_i),
    .iss_src1_i    (iss_src1_i),
    .iss_src2_i    (iss_src2_i),
    .opnd_valid_o  (opnd_valid_o),
    .opnd1_o       (opnd1_o),
    .opnd2_o       (opnd2_o),
    .opnd1_rdy_o   (opnd1_rdy_o),
    .opnd2_rdy_o   (opnd2_rdy_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;  // period 20

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------

  task automatic drive_idle();
    alloc_valid_i = '0;
    alloc_tag_i   = '0;
    bc_valid_i    = '0;
    bc_tag_i      = '0;
    bc_data_i     = '0;
    iss_valid_i   = '0;
    iss_src1_i    = '0;
    iss_src2_i    = '0;
  endtask

  task automatic apply_line(input int n);
    int base;
    base = n * FIELDS;
    alloc_valid_i = pat[base+F_AV][`PRF_DP_NUM-1:0];
    bc_valid_i    = pat[base+F_BV][`PRF_DP_NUM-1:0];
    iss_valid_i   = pat[base+F_IV][`PRF_DP_NUM-1:0];
    for (int c = 0; c < `PRF_DP_NUM; c++) begin
      alloc_tag_i[c] = prf_pkg::preg_t'(pat[base+F_ATAG+c]);
      bc_tag_i[c]    = prf_pkg::preg_t'(pat[base+F_BTAG+c]);
      bc_data_i[c]   = prf_pkg::xlen_t'(pat[base+F_BDATA+c]);
      iss_src1_i[c]  = prf_pkg::preg_t'(pat[base+F_SRC+2*c]);
      iss_src2_i[c]  = prf_pkg::preg_t'(pat[base+F_SRC+2*c+1]);
    end
  endtask

  function automatic int line_test_id(input int n);
    return int'(pat[n*FIELDS+F_TEST]);
  endfunction

  // ---------------------------------------------------------------------------
  // compare tasks
  // ---------------------------------------------------------------------------

  task automatic check_data(input string name, input prf_pkg::xlen_t exp,
                            input prf_pkg::xlen_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      err_test++;
      err_total++;
    end
  endtask

  task automatic check_rdy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      err_test++;
      err_total++;
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      err_test++;
      err_total++;
    end
  endtask

  // outputs now hold the issue group of line n
  task automatic check_line(input int n);
    int base;
    base = n * FIELDS;
    for (int c = 0; c < `PRF_DP_NUM; c++) begin
      check_valid($sformatf("opnd_valid_o[%0d]", c), pat[base+F_EV][c], opnd_valid_o[c]);
      check_data($sformatf("opnd1_o[%0d]", c),
                 prf_pkg::xlen_t'(pat[base+F_EDATA+2*c]), opnd1_o[c]);
      check_data($sformatf("opnd2_o[%0d]", c),
                 prf_pkg::xlen_t'(pat[base+F_EDATA+2*c+1]), opnd2_o[c]);
      check_rdy($sformatf("opnd1_rdy_o[%0d]", c), pat[base+F_ER1][c], opnd1_rdy_o[c]);
      check_rdy($sformatf("opnd2_rdy_o[%0d]", c), pat[base+F_ER2][c], opnd2_rdy_o[c]);
    end
  endtask

  task automatic close_test(input int id);
    tests_run++;
    if (err_test == 0) begin
      $display("test %0d: ok", id);
    end else begin
      $display("test %0d: %0d errors", id, err_test);
      tests_failed++;
    end
    err_test = 0;
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------

  initial begin
    rst_i = 1'b1;
    drive_idle();
    $readmemh("prf_patterns.mem", pat);
    while (n_pat < MAX_LINES && pat[n_pat*FIELDS+F_TEST] != 0) begin
      n_pat++;
    end
    cycle_limit = n_pat + 20 + 2;  // patterns, slack, reset
    if (n_pat == 0) begin
      $display("error: no patterns could be loaded from prf_patterns.mem");
      err_total++;
    end else begin
      repeat (2) @(posedge clk_i);  // 2 reset cycles
      for (int i = 0; i <= n_pat; i++) begin
        if (i > 0) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        if (i < n_pat) apply_line(i);
        else drive_idle();
        #16;  // just before the next edge
        if (i > 0) begin
          check_line(i - 1);
          if (i == n_pat || line_test_id(i) != line_test_id(i - 1)) begin
            close_test(line_test_id(i - 1));
          end
        end
      end
    end
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
    if (err_total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog, counts cycles since time 0
  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: run did not end within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule

// ==== prf_patterns.mem ====
// tt av a0 a1 bv b0 b1 d0 d1 iv s1_0 s2_0 s1_1 s2_1 ev op1_0 op2_0 op1_1 op2_1 r1 r2
// inputs of one cycle, then the outputs expected on the next; all hex, tt 00 ends
// test 1: state after reset
01 0 00 00 0 00 00 00000000 00000000 3 05 3f 10 00 3 00000000 00000000 00000000 00000000 3 3
01 0 00 00 0 00 00 00000000 00000000 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
01 0 00 00 0 00 00 00000000 00000000 1 2a 11 00 00 1 00000000 00000000 00000000 00000000 1 1
01 0 00 00 0 00 00 00000000 00000000 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
// test 2: broadcast then read later
02 0 00 00 3 05 06 11110005 22220006 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
02 0 00 00 1 07 00 33330007 00000000 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
02 0 00 00 0 00 00 00000000 00000000 3 05 06 07 05 3 11110005 22220006 33330007 11110005 3 3
02 0 00 00 0 00 00 00000000 00000000 2 05 05 06 07 2 00000000 00000000 22220006 33330007 2 2
02 0 00 00 2 00 05 00000000 55550005 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
02 0 00 00 0 00 00 00000000 00000000 1 05 07 00 00 1 55550005 33330007 00000000 00000000 1 1
// test 3: same-cycle forwarding
03 0 00 00 3 08 09 a0a00008 b0b00009 3 08 09 09 05 3 a0a00008 b0b00009 b0b00009 55550005 3 3
03 0 00 00 1 05 00 cafe0005 00000000 3 05 08 0a 05 3 cafe0005 a0a00008 00000000 cafe0005 3 3
03 1 0b 00 0 00 00 00000000 00000000 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
03 0 00 00 2 00 0b 00000000 0bad000b 1 0b 0b 00 00 1 0bad000b 0bad000b 00000000 00000000 1 1
// test 4: zero register
04 0 00 00 1 00 00 deadbeef 00000000 1 00 00 00 00 1 00000000 00000000 00000000 00000000 1 1
04 0 00 00 2 00 00 00000000 12345678 2 00 00 00 08 2 00000000 00000000 00000000 a0a00008 2 2
04 0 00 00 0 00 00 00000000 00000000 3 00 05 00 00 3 00000000 cafe0005 00000000 00000000 3 3
04 1 00 00 0 00 00 00000000 00000000 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
04 0 00 00 0 00 00 00000000 00000000 1 00 00 00 00 1 00000000 00000000 00000000 00000000 1 1
// test 5: allocation and wakeup
05 3 0c 0d 0 00 00 00000000 00000000 3 0c 0d 0c 0d 3 00000000 00000000 00000000 00000000 3 3
05 0 00 00 0 00 00 00000000 00000000 3 0c 05 0d 0c 3 00000000 cafe0005 00000000 00000000 0 1
05 0 00 00 0 00 00 00000000 00000000 1 0d 0d 00 00 1 00000000 00000000 00000000 00000000 0 0
05 0 00 00 1 0c 00 c0c0000c 00000000 3 0c 0d 0d 0c 3 c0c0000c 00000000 00000000 c0c0000c 1 2
05 0 00 00 0 00 00 00000000 00000000 1 0c 0d 00 00 1 c0c0000c 00000000 00000000 00000000 1 0
05 0 00 00 2 00 0d 00000000 d0d0000d 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
05 0 00 00 0 00 00 00000000 00000000 2 00 00 0d 0c 2 00000000 00000000 d0d0000d c0c0000c 2 2
05 2 00 05 0 00 00 00000000 00000000 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
05 0 00 00 0 00 00 00000000 00000000 1 05 0c 00 00 1 cafe0005 c0c0000c 00000000 00000000 0 1
// test 6: back-to-back issue on both lanes
06 0 00 00 3 10 11 10101010 11111111 3 10 11 05 0c 3 10101010 11111111 cafe0005 c0c0000c 1 3
06 0 00 00 1 05 00 5a5a0005 00000000 3 11 05 05 10 3 11111111 5a5a0005 5a5a0005 10101010 3 3
06 1 12 00 2 00 13 00000000 13131313 3 13 12 0d 09 3 13131313 00000000 d0d0000d b0b00009 3 3
06 0 00 00 0 00 00 00000000 00000000 3 12 13 10 12 3 00000000 13131313 10101010 00000000 2 1
06 0 00 00 1 12 00 12121212 00000000 3 12 00 12 11 3 12121212 00000000 12121212 11111111 3 3
06 0 00 00 0 00 00 00000000 00000000 2 00 00 12 05 2 00000000 00000000 12121212 5a5a0005 2 2
06 0 00 00 0 00 00 00000000 00000000 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0
// end marker
00 0 00 00 0 00 00 00000000 00000000 0 00 00 00 00 0 00000000 00000000 00000000 00000000 0 0

// ==== all.f ====
+incdir+.
prf_pkg.sv
prf.sv
prf_busy_table.sv
operand_read.sv
prf_subsys.sv
tb_prf_subsys.sv

// ==== Makefile ====
# Verilator build and run for the prf subsystem testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_prf_subsys
FILELIST := all.f
OBJDIR   := obj_dir
LOG      := sim.log
FAIL_MSG := FAIL: see errors above

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# an abnormal exit of the simulator counts as a failure
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
